// File: design/regmap_pkg.sv
// **********************************************************************
// Register bus types, address map and identification words
// Addresses are word addresses on the 10-bit register bus
// **********************************************************************

package regmap_pkg;

  typedef logic [9:0]  up_addr_t;
  typedef logic [31:0] up_data_t;

  // Word offset inside a channel page
  typedef logic [3:0]  chan_off_t;

  // Identification words
  localparam up_data_t PCORE_VERSION = 32'h000a_0161;
  localparam up_data_t CORE_ID       = 32'h0000_0001;

  // **********************************************************************
  // Common page, 0x000 to 0x03F
  // **********************************************************************
  localparam up_addr_t COMMON_LAST    = 10'h03f;
  localparam up_addr_t ADDR_VERSION   = 10'h000;
  localparam up_addr_t ADDR_ID        = 10'h001;
  localparam up_addr_t ADDR_SCRATCH   = 10'h002;
  localparam up_addr_t ADDR_CLK_RATIO = 10'h015;
  localparam up_addr_t ADDR_STATUS    = 10'h017;
  localparam up_addr_t ADDR_OVF       = 10'h018;

  // Transport page, 0x080 to 0x09F
  localparam up_addr_t TPL_FIRST        = 10'h080;
  localparam up_addr_t TPL_LAST         = 10'h09f;
  localparam up_addr_t ADDR_PROFILE_NUM = 10'h080;
  localparam up_addr_t ADDR_PROFILE_SEL = 10'h081;
  localparam up_addr_t ADDR_JESD_MLSF   = 10'h090;
  localparam up_addr_t ADDR_JESD_NNP    = 10'h091;

  // Channel pages, one per channel of 16 words
  localparam up_addr_t  CHAN_BASE   = 10'h100;
  localparam up_addr_t  CHAN_STRIDE = 10'h010;
  localparam chan_off_t CH_CTRL     = 4'h0;
  localparam chan_off_t CH_STATUS   = 4'h1;
  localparam chan_off_t CH_PNSEL    = 4'h9;

endpackage

// File: design/adc_cfg_pkg.sv
// **********************************************************************
// Converter-side sizes and field types
// Profile select width must hold NUM_PROFILES-1
// **********************************************************************

package adc_cfg_pkg;

  // Core configuration
  localparam int NUM_CHANNELS    = 4;
  localparam int NUM_PROFILES    = 2;

  // Samples per link clock
  localparam int DATA_PATH_WIDTH = 4;

  // One bit per converter channel
  typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

  // PN sequence select code
  typedef logic [3:0] pn_sel_t;

  // One JESD link parameter, one byte per profile on the ports
  typedef logic [7:0] jesd_param_t;

  // Profile number
  typedef logic [1:0] profile_sel_t;

endpackage

// File: design/up_adc_common.sv
// **********************************************************************
// Common registers of the ADC transport core
// PN summary inputs are registered once more before STATUS shows them
// **********************************************************************

`timescale 1ns/1ps

module up_adc_common
  import regmap_pkg::*;
  import adc_cfg_pkg::*;
(
  input  logic     link_clk,
  input  logic     adc_rst,

  input  logic     up_wreq,
  input  up_addr_t up_waddr,
  input  up_data_t up_wdata,
  output logic     up_wack,
  input  logic     up_rreq,
  input  up_addr_t up_raddr,
  output up_data_t up_rdata,
  output logic     up_rack,

  input  logic     adc_dovf,
  input  logic     status_pn_err,
  input  logic     status_pn_oos
);

  logic     wsel;
  logic     rsel;
  up_data_t scratch;
  logic     ovf_sticky;
  logic     pn_err_q;
  logic     pn_oos_q;
  up_data_t rd_word;

  // Page decode
  assign wsel = up_wreq && (up_waddr <= COMMON_LAST);
  assign rsel = up_rreq && (up_raddr <= COMMON_LAST);

  // **********************************************************************
  // Write side and status capture
  // **********************************************************************
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack    <= 1'b0;
      scratch    <= '0;
      ovf_sticky <= 1'b0;
      pn_err_q   <= 1'b0;
      pn_oos_q   <= 1'b0;
    end else begin
      up_wack  <= wsel;
      pn_err_q <= status_pn_err;
      pn_oos_q <= status_pn_oos;
      if (wsel && (up_waddr == ADDR_SCRATCH)) begin
        scratch <= up_wdata;
      end
      // A new overflow beats a clear in the same cycle
      if (adc_dovf) begin
        ovf_sticky <= 1'b1;
      end else if (wsel && (up_waddr == ADDR_OVF) && up_wdata[0]) begin
        ovf_sticky <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    rd_word = '0;
    case (up_raddr)
      ADDR_VERSION:   rd_word = PCORE_VERSION;
      ADDR_ID:        rd_word = CORE_ID;
      ADDR_SCRATCH:   rd_word = scratch;
      // Data path ratio in the upper half and channel count in the low byte
      ADDR_CLK_RATIO: rd_word = {16'(DATA_PATH_WIDTH), 8'h00, 8'(NUM_CHANNELS)};
      ADDR_STATUS:    rd_word[2:1] = {pn_oos_q, pn_err_q};
      ADDR_OVF:       rd_word[0] = ovf_sticky;
      default:        rd_word = '0;
    endcase
  end

  // Read reply is zero when not claimed
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= rsel;
      up_rdata <= rsel ? rd_word : '0;
    end
  end

endmodule

// File: design/up_adc_channel.sv
// **********************************************************************
// Per-channel control and status registers
// The page sits at CHAN_BASE + CHAN_STRIDE * CHANNEL_ID
// **********************************************************************

`timescale 1ns/1ps

module up_adc_channel
  import regmap_pkg::*;
  import adc_cfg_pkg::*;
#(
  parameter int CHANNEL_ID = 0
) (
  input  logic     link_clk,
  input  logic     adc_rst,

  input  logic     up_wreq,
  input  up_addr_t up_waddr,
  input  up_data_t up_wdata,
  output logic     up_wack,
  input  logic     up_rreq,
  input  up_addr_t up_raddr,
  output up_data_t up_rdata,
  output logic     up_rack,

  input  logic     pn_err,
  input  logic     pn_oos,

  output logic     enable,
  output logic     dfmt_enable,
  output logic     dfmt_sign_extend,
  output logic     dfmt_type,
  output pn_sel_t  pn_seq_sel,
  output logic     pn_err_sticky
);

  logic      wsel;
  logic      rsel;
  chan_off_t woff;
  chan_off_t roff;
  up_data_t  rd_word;

  // Own page decoded on the upper six address bits
  assign wsel = up_wreq &&
                (up_waddr[9:4] == 6'((CHAN_BASE + CHAN_STRIDE * CHANNEL_ID) >> 4));
  assign rsel = up_rreq &&
                (up_raddr[9:4] == 6'((CHAN_BASE + CHAN_STRIDE * CHANNEL_ID) >> 4));
  assign woff = up_waddr[3:0];
  assign roff = up_raddr[3:0];

  // **********************************************************************
  // Control registers
  // **********************************************************************
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack          <= 1'b0;
      enable           <= 1'b0;
      dfmt_enable      <= 1'b0;
      dfmt_sign_extend <= 1'b0;
      dfmt_type        <= 1'b0;
      pn_seq_sel       <= '0;
    end else begin
      up_wack <= wsel;
      if (wsel && (woff == CH_CTRL)) begin
        enable           <= up_wdata[0];
        dfmt_type        <= up_wdata[4];
        dfmt_sign_extend <= up_wdata[5];
        dfmt_enable      <= up_wdata[6];
      end
      if (wsel && (woff == CH_PNSEL)) begin
        pn_seq_sel <= up_wdata[19:16];
      end
    end
  end

  // Sticky PN error where set wins over clear
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      pn_err_sticky <= 1'b0;
    end else if (pn_err) begin
      pn_err_sticky <= 1'b1;
    end else if (wsel && (woff == CH_STATUS) && up_wdata[1]) begin
      pn_err_sticky <= 1'b0;
    end
  end

  // **********************************************************************
  // Readback
  // **********************************************************************
  always_comb begin
    rd_word = '0;
    case (roff)
      CH_CTRL: begin
        rd_word[0] = enable;
        rd_word[4] = dfmt_type;
        rd_word[5] = dfmt_sign_extend;
        rd_word[6] = dfmt_enable;
      end
      // Bit 2 is the live out-of-sync state
      CH_STATUS: rd_word[2:1]   = {pn_oos, pn_err_sticky};
      CH_PNSEL:  rd_word[19:16] = pn_seq_sel;
      default:   rd_word        = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= rsel;
      up_rdata <= rsel ? rd_word : '0;
    end
  end

endmodule

// File: design/up_tpl_common.sv
// **********************************************************************
// JESD profile select and link parameter readback
// A profile number at or above NUM_PROFILES reads zero parameters
// **********************************************************************

`timescale 1ns/1ps

module up_tpl_common
  import regmap_pkg::*;
  import adc_cfg_pkg::*;
(
  input  logic                           link_clk,
  input  logic                           adc_rst,

  input  logic                           up_wreq,
  input  up_addr_t                       up_waddr,
  input  up_data_t                       up_wdata,
  output logic                           up_wack,
  input  logic                           up_rreq,
  input  up_addr_t                       up_raddr,
  output up_data_t                       up_rdata,
  output logic                           up_rack,

  input  jesd_param_t [NUM_PROFILES-1:0] jesd_m,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_l,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_s,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_f,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_n,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_np,

  output profile_sel_t                   profile_sel
);

  logic        wsel;
  logic        rsel;
  jesd_param_t sel_m, sel_l, sel_s, sel_f, sel_n, sel_np;
  up_data_t    rd_word;

  assign wsel = up_wreq && (up_waddr >= TPL_FIRST) && (up_waddr <= TPL_LAST);
  assign rsel = up_rreq && (up_raddr >= TPL_FIRST) && (up_raddr <= TPL_LAST);

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack     <= 1'b0;
      profile_sel <= '0;
    end else begin
      up_wack <= wsel;
      if (wsel && (up_waddr == ADDR_PROFILE_SEL)) begin
        profile_sel <= up_wdata[$bits(profile_sel_t)-1:0];
      end
    end
  end

  // Byte p of each parameter port belongs to profile p
  always_comb begin
    sel_m  = '0;
    sel_l  = '0;
    sel_s  = '0;
    sel_f  = '0;
    sel_n  = '0;
    sel_np = '0;
    for (int p = 0; p < NUM_PROFILES; p++) begin
      if (profile_sel == profile_sel_t'(p)) begin
        sel_m  = jesd_m[p];
        sel_l  = jesd_l[p];
        sel_s  = jesd_s[p];
        sel_f  = jesd_f[p];
        sel_n  = jesd_n[p];
        sel_np = jesd_np[p];
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (up_raddr)
      ADDR_PROFILE_NUM: rd_word = up_data_t'(NUM_PROFILES - 1);
      ADDR_PROFILE_SEL: rd_word = up_data_t'(profile_sel);
      ADDR_JESD_MLSF:   rd_word = {sel_f, sel_s, sel_l, sel_m};
      ADDR_JESD_NNP:    rd_word = {16'h0000, sel_np, sel_n};
      default:          rd_word = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= rsel;
      up_rdata <= rsel ? rd_word : '0;
    end
  end

endmodule

// File: design/tpl_adc_regmap.sv
// **********************************************************************
// Register map top of the JESD transport ADC core
// Replies arrive 2 cycles after the request, unmapped addresses never ack
// **********************************************************************

`timescale 1ns/1ps

module tpl_adc_regmap
  import regmap_pkg::*;
  import adc_cfg_pkg::*;
(
  input  logic                           link_clk,
  input  logic                           adc_rst,

  // Register bus
  input  logic                           up_wreq,
  input  up_addr_t                       up_waddr,
  input  up_data_t                       up_wdata,
  output logic                           up_wack,
  input  logic                           up_rreq,
  input  up_addr_t                       up_raddr,
  output up_data_t                       up_rdata,
  output logic                           up_rack,

  // Data path control and status
  output chan_mask_t                     enable,
  output chan_mask_t                     dfmt_enable,
  output chan_mask_t                     dfmt_sign_extend,
  output chan_mask_t                     dfmt_type,
  output pn_sel_t [NUM_CHANNELS-1:0]     pn_seq_sel,
  input  chan_mask_t                     pn_err,
  input  chan_mask_t                     pn_oos,
  input  logic                           adc_dovf,

  // Deframer link parameters, one byte per profile
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_m,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_l,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_s,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_f,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_n,
  input  jesd_param_t [NUM_PROFILES-1:0] jesd_np,
  output profile_sel_t                   profile_sel
);

  logic       common_wack, common_rack;
  up_data_t   common_rdata;
  logic       tpl_wack, tpl_rack;
  up_data_t   tpl_rdata;
  chan_mask_t chan_wack, chan_rack;
  up_data_t   chan_rdata [NUM_CHANNELS];
  chan_mask_t pn_err_sticky;
  up_data_t   rdata_all;
  logic       status_pn_err;
  logic       status_pn_oos;

  // **********************************************************************
  // Reply merge
  // **********************************************************************
  always_comb begin
    rdata_all = common_rdata | tpl_rdata;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      rdata_all = rdata_all | chan_rdata[i];
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack       <= 1'b0;
      up_rack       <= 1'b0;
      up_rdata      <= '0;
      status_pn_err <= 1'b0;
      status_pn_oos <= 1'b0;
    end else begin
      up_wack       <= common_wack | tpl_wack | (|chan_wack);
      up_rack       <= common_rack | tpl_rack | (|chan_rack);
      up_rdata      <= rdata_all;
      // PN summary for the common STATUS register
      status_pn_err <= |pn_err_sticky;
      status_pn_oos <= |pn_oos;
    end
  end

  up_adc_common up_adc_common_inst (
    .link_clk      (link_clk),
    .adc_rst       (adc_rst),
    .up_wreq       (up_wreq),
    .up_waddr      (up_waddr),
    .up_wdata      (up_wdata),
    .up_wack       (common_wack),
    .up_rreq       (up_rreq),
    .up_raddr      (up_raddr),
    .up_rdata      (common_rdata),
    .up_rack       (common_rack),
    .adc_dovf      (adc_dovf),
    .status_pn_err (status_pn_err),
    .status_pn_oos (status_pn_oos)
  );

  // One register page per converter channel
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
    up_adc_channel #(
      .CHANNEL_ID (i)
    ) up_adc_channel_inst (
      .link_clk         (link_clk),
      .adc_rst          (adc_rst),
      .up_wreq          (up_wreq),
      .up_waddr         (up_waddr),
      .up_wdata         (up_wdata),
      .up_wack          (chan_wack[i]),
      .up_rreq          (up_rreq),
      .up_raddr         (up_raddr),
      .up_rdata         (chan_rdata[i]),
      .up_rack          (chan_rack[i]),
      .pn_err           (pn_err[i]),
      .pn_oos           (pn_oos[i]),
      .enable           (enable[i]),
      .dfmt_enable      (dfmt_enable[i]),
      .dfmt_sign_extend (dfmt_sign_extend[i]),
      .dfmt_type        (dfmt_type[i]),
      .pn_seq_sel       (pn_seq_sel[i]),
      .pn_err_sticky    (pn_err_sticky[i])
    );
  end

  up_tpl_common up_tpl_common_inst (
    .link_clk    (link_clk),
    .adc_rst     (adc_rst),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .up_wack     (tpl_wack),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_rdata    (tpl_rdata),
    .up_rack     (tpl_rack),
    .jesd_m      (jesd_m),
    .jesd_l      (jesd_l),
    .jesd_s      (jesd_s),
    .jesd_f      (jesd_f),
    .jesd_n      (jesd_n),
    .jesd_np     (jesd_np),
    .profile_sel (profile_sel)
  );

endmodule

// File: sim/tb_tpl_adc_regmap.sv
// **********************************************************************
// Directed testbench for the register map top level
// Bus replies are checked at exactly 2 cycles on the falling edge
// **********************************************************************

`timescale 1ns/1ps

module tb_tpl_adc_regmap
  import regmap_pkg::*;
  import adc_cfg_pkg::*;
();

  localparam logic [31:0] SEED           = 32'hd8de1b82;
  localparam int          TIMEOUT_CYCLES = 3000;
  localparam up_addr_t    ADDR_UNMAPPED  = 10'h060;

  logic                           link_clk;
  logic                           adc_rst;
  logic                           up_wreq;
  up_addr_t                       up_waddr;
  up_data_t                       up_wdata;
  logic                           up_wack;
  logic                           up_rreq;
  up_addr_t                       up_raddr;
  up_data_t                       up_rdata;
  logic                           up_rack;
  chan_mask_t                     enable;
  chan_mask_t                     dfmt_enable;
  chan_mask_t                     dfmt_sign_extend;
  chan_mask_t                     dfmt_type;
  pn_sel_t [NUM_CHANNELS-1:0]     pn_seq_sel;
  chan_mask_t                     pn_err;
  chan_mask_t                     pn_oos;
  logic                           adc_dovf;
  jesd_param_t [NUM_PROFILES-1:0] jesd_m;
  jesd_param_t [NUM_PROFILES-1:0] jesd_l;
  jesd_param_t [NUM_PROFILES-1:0] jesd_s;
  jesd_param_t [NUM_PROFILES-1:0] jesd_f;
  jesd_param_t [NUM_PROFILES-1:0] jesd_n;
  jesd_param_t [NUM_PROFILES-1:0] jesd_np;
  profile_sel_t                   profile_sel;

  int       errors;
  int       cycles;
  up_data_t scratch_last;
  // Expected CTRL and PNSEL words per channel
  up_data_t exp_ctrl  [NUM_CHANNELS];
  up_data_t exp_pnsel [NUM_CHANNELS];

  tpl_adc_regmap tpl_adc_regmap_inst (
    .link_clk (link_clk), .adc_rst (adc_rst),
    .up_wreq (up_wreq), .up_waddr (up_waddr), .up_wdata (up_wdata), .up_wack (up_wack),
    .up_rreq (up_rreq), .up_raddr (up_raddr), .up_rdata (up_rdata), .up_rack (up_rack),
    .enable (enable), .dfmt_enable (dfmt_enable), .dfmt_sign_extend (dfmt_sign_extend),
    .dfmt_type (dfmt_type), .pn_seq_sel (pn_seq_sel),
    .pn_err (pn_err), .pn_oos (pn_oos), .adc_dovf (adc_dovf),
    .jesd_m (jesd_m), .jesd_l (jesd_l), .jesd_s (jesd_s), .jesd_f (jesd_f),
    .jesd_n (jesd_n), .jesd_np (jesd_np), .profile_sel (profile_sel)
  );

  initial begin
    link_clk = 1'b0;
    forever #5 link_clk = ~link_clk;
  end

  // **********************************************************************
  // Bus access and checking
  // **********************************************************************
  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("[ERROR] %0t ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic up_addr_t chan_addr(input int ch, input chan_off_t off);
    return up_addr_t'(CHAN_BASE + CHAN_STRIDE * ch) | up_addr_t'(off);
  endfunction

  task automatic bus_write(input up_addr_t addr, input up_data_t data);
    @(posedge link_clk);
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    @(posedge link_clk);
    up_wreq  <= 1'b0;
    @(negedge link_clk);
    check_word($sformatf("early write ack at 0x%03h", addr), 32'(up_wack), 0);
    @(negedge link_clk);
    check_word($sformatf("write ack at 0x%03h", addr), 32'(up_wack), 1);
  endtask

  task automatic bus_read(input up_addr_t addr, output up_data_t data);
    @(posedge link_clk);
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    @(posedge link_clk);
    up_rreq  <= 1'b0;
    @(negedge link_clk);
    check_word($sformatf("early read ack at 0x%03h", addr), 32'(up_rack), 0);
    @(negedge link_clk);
    check_word($sformatf("read ack at 0x%03h", addr), 32'(up_rack), 1);
    data = up_rdata;
  endtask

  task automatic read_expect(input up_addr_t addr, input up_data_t exp, input string what);
    up_data_t rd;
    bus_read(addr, rd);
    check_word(what, rd, exp);
  endtask

  task automatic check_chan_outputs;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      check_word($sformatf("enable[%0d]", c), 32'(enable[c]), 32'(exp_ctrl[c][0]));
      check_word($sformatf("dfmt_type[%0d]", c), 32'(dfmt_type[c]), 32'(exp_ctrl[c][4]));
      check_word($sformatf("dfmt_sign_extend[%0d]", c), 32'(dfmt_sign_extend[c]),
                 32'(exp_ctrl[c][5]));
      check_word($sformatf("dfmt_enable[%0d]", c), 32'(dfmt_enable[c]), 32'(exp_ctrl[c][6]));
      check_word($sformatf("pn_seq_sel[%0d]", c), 32'(pn_seq_sel[c]),
                 32'(exp_pnsel[c][19:16]));
    end
  endtask

  // **********************************************************************
  // Directed tests
  // **********************************************************************
  task automatic reset_and_id_regs;
    @(negedge link_clk);
    check_word("enable after reset", 32'(enable), 0);
    check_word("dfmt_enable after reset", 32'(dfmt_enable), 0);
    check_word("dfmt_sign_extend after reset", 32'(dfmt_sign_extend), 0);
    check_word("dfmt_type after reset", 32'(dfmt_type), 0);
    check_word("pn_seq_sel after reset", 32'(pn_seq_sel), 0);
    check_word("profile_sel after reset", 32'(profile_sel), 0);
    read_expect(ADDR_VERSION, PCORE_VERSION, "VERSION");
    read_expect(ADDR_ID, CORE_ID, "ID");
    read_expect(ADDR_CLK_RATIO, (32'(DATA_PATH_WIDTH) << 16) | 32'(NUM_CHANNELS), "CLK_RATIO");
    read_expect(ADDR_SCRATCH, 32'h0, "SCRATCH after reset");
    repeat (4) begin
      scratch_last = $urandom;
      bus_write(ADDR_SCRATCH, scratch_last);
      read_expect(ADDR_SCRATCH, scratch_last, "SCRATCH readback");
    end
  endtask

  task automatic channel_ctrl_regs;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      exp_ctrl[c]  = '0;
      exp_pnsel[c] = '0;
    end
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      exp_ctrl[ch]  = $urandom;
      exp_pnsel[ch] = $urandom;
      bus_write(chan_addr(ch, CH_CTRL), exp_ctrl[ch]);
      bus_write(chan_addr(ch, CH_PNSEL), exp_pnsel[ch]);
      check_chan_outputs();
      read_expect(chan_addr(ch, CH_CTRL), exp_ctrl[ch] & 32'h0000_0071, "CTRL readback");
      read_expect(chan_addr(ch, CH_PNSEL), exp_pnsel[ch] & 32'h000f_0000, "PNSEL readback");
    end
  endtask

  task automatic pn_status_flags;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      // One-cycle PN error pulse
      @(posedge link_clk);
      pn_err <= chan_mask_t'(1 << ch);
      @(posedge link_clk);
      pn_err <= '0;
      read_expect(chan_addr(ch, CH_STATUS), 32'h2, "channel STATUS after pn_err");
      read_expect(ADDR_STATUS, 32'h2, "common STATUS after pn_err");
      bus_write(chan_addr(ch, CH_STATUS), 32'h2);
      read_expect(chan_addr(ch, CH_STATUS), 32'h0, "channel STATUS after clear");
      read_expect(ADDR_STATUS, 32'h0, "common STATUS after clear");
      // Out-of-sync held and then released
      @(posedge link_clk);
      pn_oos <= chan_mask_t'(1 << ch);
      read_expect(chan_addr(ch, CH_STATUS), 32'h4, "channel STATUS with pn_oos");
      read_expect(ADDR_STATUS, 32'h4, "common STATUS with pn_oos");
      @(posedge link_clk);
      pn_oos <= '0;
      read_expect(chan_addr(ch, CH_STATUS), 32'h0, "channel STATUS after pn_oos");
      read_expect(ADDR_STATUS, 32'h0, "common STATUS after pn_oos");
    end
  endtask

  task automatic overflow_flag;
    read_expect(ADDR_OVF, 32'h0, "OVF before overflow");
    @(posedge link_clk);
    adc_dovf <= 1'b1;
    @(posedge link_clk);
    adc_dovf <= 1'b0;
    read_expect(ADDR_OVF, 32'h1, "OVF after overflow");
    read_expect(ADDR_OVF, 32'h1, "OVF held");
    bus_write(ADDR_OVF, 32'h0);
    read_expect(ADDR_OVF, 32'h1, "OVF after writing zero");
    bus_write(ADDR_OVF, 32'h1);
    read_expect(ADDR_OVF, 32'h0, "OVF after clear");
  endtask

  task automatic profile_select;
    @(posedge link_clk);
    jesd_m  <= 16'($urandom);
    jesd_l  <= 16'($urandom);
    jesd_s  <= 16'($urandom);
    jesd_f  <= 16'($urandom);
    jesd_n  <= 16'($urandom);
    jesd_np <= 16'($urandom);
    read_expect(ADDR_PROFILE_NUM, 32'(NUM_PROFILES - 1), "PROFILE_NUM");
    for (int p = NUM_PROFILES - 1; p >= 0; p--) begin
      bus_write(ADDR_PROFILE_SEL, up_data_t'(p));
      check_word("profile_sel", 32'(profile_sel), p);
      read_expect(ADDR_PROFILE_SEL, up_data_t'(p), "PROFILE_SEL readback");
      read_expect(ADDR_JESD_MLSF, {jesd_f[p], jesd_s[p], jesd_l[p], jesd_m[p]}, "JESD_MLSF");
      read_expect(ADDR_JESD_NNP, {16'h0000, jesd_np[p], jesd_n[p]}, "JESD_NNP");
    end
  endtask

  task automatic pipelined_and_unmapped;
    up_addr_t addrs [3];
    up_data_t exp   [3];
    addrs = '{ADDR_VERSION, ADDR_ID, ADDR_SCRATCH};
    exp   = '{PCORE_VERSION, CORE_ID, scratch_last};
    // Reads on three consecutive cycles with ack k in cycle k + 2
    for (int c = 0; c < 6; c++) begin
      @(posedge link_clk);
      if (c < 3) begin
        up_rreq  <= 1'b1;
        up_raddr <= addrs[c];
      end else begin
        up_rreq  <= 1'b0;
      end
      @(negedge link_clk);
      if (c >= 2 && c < 5) begin
        check_word($sformatf("pipelined read ack %0d", c - 2), 32'(up_rack), 1);
        check_word($sformatf("pipelined read data %0d", c - 2), up_rdata, exp[c - 2]);
      end else begin
        check_word($sformatf("pipelined read idle cycle %0d", c), 32'(up_rack), 0);
      end
    end
    // Write and read outside every page in the same cycle
    @(posedge link_clk);
    up_wreq  <= 1'b1;
    up_waddr <= ADDR_UNMAPPED;
    up_wdata <= $urandom;
    up_rreq  <= 1'b1;
    up_raddr <= ADDR_UNMAPPED;
    @(posedge link_clk);
    up_wreq  <= 1'b0;
    up_rreq  <= 1'b0;
    repeat (4) begin
      @(negedge link_clk);
      check_word("write ack on unmapped address", 32'(up_wack), 0);
      check_word("read ack on unmapped address", 32'(up_rack), 0);
    end
  endtask

  // **********************************************************************
  // Run control
  // **********************************************************************
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge link_clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors: %0d", errors);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    errors       = 0;
    scratch_last = '0;
    void'($urandom(SEED));
    adc_rst  <= 1'b1;
    up_wreq  <= 1'b0;
    up_waddr <= '0;
    up_wdata <= '0;
    up_rreq  <= 1'b0;
    up_raddr <= '0;
    pn_err   <= '0;
    pn_oos   <= '0;
    adc_dovf <= 1'b0;
    jesd_m   <= '0;
    jesd_l   <= '0;
    jesd_s   <= '0;
    jesd_f   <= '0;
    jesd_n   <= '0;
    jesd_np  <= '0;
    repeat (10) @(posedge link_clk);
    adc_rst <= 1'b0;
    reset_and_id_regs();
    channel_ctrl_regs();
    pn_status_flags();
    overflow_flag();
    profile_select();
    pipelined_and_unmapped();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
design/regmap_pkg.sv
design/adc_cfg_pkg.sv
design/up_adc_common.sv
design/up_adc_channel.sv
design/up_tpl_common.sv
design/tpl_adc_regmap.sv
sim/tb_tpl_adc_regmap.sv
